//--- Bender.yml
package:
  name: levinson_top

sources:
  - files:
      - lpc_fmt_pkg.sv
      - lpc_seq_pkg.sv
      - sdiv_seq.sv
      - corr_dot.sv
      - coef_update.sv
      - levinson_ctrl.sv
      - levinson_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_levinson_top.sv

//--- coef_update.sv
`timescale 1ns/10ps
`default_nettype none

module coef_update (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   init,
  input  logic                   upd_start,
  input  lpc_seq_pkg::upd_req_t  upd_req,
  output logic                   upd_done,
  output lpc_fmt_pkg::coef_vec_t coefs
);
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  coef_vec_t a_q;
  coef_t     k_q;
  stage_t    i_q;
  stage_t    j_q;
  stage_t    hi;
  logic      run_q;

  // base + ((k * other) >>> COEF_FRAC), clipped to coef_t
  function automatic coef_t mac_sat(coef_t base, coef_t k, coef_t other);
    logic signed [2*$bits(coef_t)-1:0] prod;
    logic signed [2*$bits(coef_t):0]   sum;
    prod = k * other;
    sum  = base + (prod >>> COEF_FRAC);
    if (sum > 32767)
      return 16'sh7fff;
    else if (sum < -32768)
      return 16'sh8000;
    else
      return coef_t'(sum);
  endfunction

  assign hi = i_q - j_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q      <= '0;
      run_q    <= 1'b0;
      upd_done <= 1'b0;
      i_q      <= '0;
      j_q      <= '0;
    end else begin
      upd_done <= 1'b0;
      if (init) begin
        a_q    <= '0;
        a_q[0] <= coef_t'(COEF_ONE);
        run_q  <= 1'b0;
      end else if (upd_start) begin
        a_q[upd_req.stage] <= upd_req.k;   // a[i] is never read by the pairs
        i_q <= upd_req.stage;
        j_q <= stage_t'(1);
        if (upd_req.stage < 4'd2)
          upd_done <= 1'b1;   // No pairs in stage 1
        else
          run_q <= 1'b1;
      end else if (run_q) begin
        // Both sides from old values
        a_q[j_q] <= mac_sat(a_q[j_q], k_q, a_q[hi]);
        if (hi != j_q)
          a_q[hi] <= mac_sat(a_q[hi], k_q, a_q[j_q]);
        if (j_q == (i_q >> 1)) begin
          run_q    <= 1'b0;
          upd_done <= 1'b1;
        end else begin
          j_q <= j_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (upd_start)
      k_q <= upd_req.k;
  end

  assign coefs = a_q;

  a_stage_range: assert property (@(posedge clk) disable iff (rst)
    upd_start |-> (upd_req.stage >= 1 && upd_req.stage <= ORDER));

endmodule

`default_nettype wire

//--- corr_dot.sv
`timescale 1ns/10ps
`default_nettype none

module corr_dot (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       capture,
  input  lpc_fmt_pkg::autocorr_vec_t autocorr,
  input  lpc_fmt_pkg::coef_vec_t     coefs,
  input  logic                       dot_start,
  input  lpc_seq_pkg::stage_t        stage,
  output logic                       dot_valid,
  output lpc_fmt_pkg::acc_t          dot_sum
);
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  autocorr_vec_t                            r_q;
  stage_t                                   stg_q;
  stage_t                                   j_q;
  stage_t                                   lag;
  logic                                     active;
  acc_t                                     acc_q;
  logic signed [$bits(coef_t)+SAMPLE_W-1:0] prod;

  assign lag  = stg_q - j_q;
  assign prod = coef_t'(coefs[j_q]) * sample_t'(r_q[lag]);   // a[j] * R[i-j], no shift

  always_ff @(posedge clk) begin
    if (capture)
      r_q <= autocorr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      dot_valid <= 1'b0;
      stg_q     <= '0;
      j_q       <= '0;
    end else begin
      dot_valid <= 1'b0;
      if (dot_start) begin
        active <= 1'b1;
        stg_q  <= stage;
        j_q    <= '0;
      end else if (active) begin
        j_q <= j_q + 1'b1;
        if (j_q + 1'b1 == stg_q) begin   // Last term j = i-1
          active    <= 1'b0;
          dot_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dot_start)
      acc_q <= '0;
    else if (active)
      acc_q <= acc_q + acc_t'(prod);
  end

  assign dot_sum = acc_q;

  a_no_restart: assert property (@(posedge clk) disable iff (rst)
    dot_start |-> !active);

endmodule

`default_nettype wire

//--- levinson_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module levinson_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  lpc_fmt_pkg::autocorr_vec_t autocorr,
  output logic                       capture,
  output logic                       init,
  output logic                       dot_start,
  output lpc_seq_pkg::stage_t        stage,
  input  logic                       dot_valid,
  input  lpc_fmt_pkg::acc_t          dot_sum,
  output logic                       div_start,
  output lpc_seq_pkg::div_req_t      div_req,
  input  logic                       div_done,
  input  lpc_seq_pkg::div_rsp_t      div_rsp,
  output logic                       upd_start,
  output lpc_seq_pkg::upd_req_t      upd_req,
  input  logic                       upd_done,
  output logic                       busy,
  output logic                       done,
  output logic                       unstable
);
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  ctrl_state_t                  state;
  sample_t                      e_q;
  sample_t                      e_nxt;
  acc_t                         q_q;
  logic                         dz_q;
  logic                         accept;
  logic                         k_bad;
  logic signed [2*SAMPLE_W-1:0] kk;
  logic signed [2*SAMPLE_W-1:0] ke;

  assign accept  = start && !busy;
  assign capture = accept;
  assign init    = accept;

  // Reflection outside (-1, 1) or no divisor
  assign k_bad = dz_q || (q_q >= acc_t'(COEF_ONE)) || (q_q <= -acc_t'(COEF_ONE));

  // E - ((k^2 * E) scaled back to sample format)
  assign kk    = (upd_req.k * upd_req.k) >>> COEF_FRAC;
  assign ke    = (kk * e_q) >>> COEF_FRAC;
  assign e_nxt = e_q - sample_t'(ke);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      stage     <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
      unstable  <= 1'b0;
      dot_start <= 1'b0;
      div_start <= 1'b0;
      upd_start <= 1'b0;
    end else begin
      done      <= 1'b0;
      dot_start <= 1'b0;
      div_start <= 1'b0;
      upd_start <= 1'b0;
      if (done)
        busy <= 1'b0;
      case (state)
        ST_IDLE: if (accept) begin
          busy     <= 1'b1;
          unstable <= 1'b0;
          stage    <= stage_t'(1);
          if (sample_t'(autocorr[0]) <= 0) begin   // Degenerate input
            done     <= 1'b1;
            unstable <= 1'b1;
          end else begin
            dot_start <= 1'b1;
            state     <= ST_DOT;
          end
        end
        ST_DOT: if (dot_valid) begin
          div_start <= 1'b1;
          state     <= ST_DIV;
        end
        ST_DIV: if (div_done)
          state <= ST_KCHK;
        ST_KCHK: if (k_bad) begin
          done     <= 1'b1;
          unstable <= 1'b1;
          state    <= ST_IDLE;
        end else begin
          upd_start <= 1'b1;
          state     <= ST_UPD;
        end
        ST_UPD: if (upd_done)
          state <= ST_EUPD;
        ST_EUPD: if (stage == ORDER) begin
          done  <= 1'b1;
          state <= ST_IDLE;
        end else if (e_nxt <= 0) begin
          done     <= 1'b1;
          unstable <= 1'b1;
          state    <= ST_IDLE;
        end else begin
          stage     <= stage + 1'b1;
          dot_start <= 1'b1;
          state     <= ST_DOT;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Datapath registers follow the state
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: if (accept) e_q <= autocorr[0];
      ST_DOT: if (dot_valid) begin
        div_req.dividend <= -dot_sum;
        div_req.divisor  <= e_q;
      end
      ST_DIV: if (div_done) begin
        q_q  <= div_rsp.quotient;
        dz_q <= div_rsp.div_zero;
      end
      ST_KCHK: begin
        upd_req.k     <= coef_t'(q_q);   // Range already checked
        upd_req.stage <= stage;
      end
      ST_EUPD: e_q <= e_nxt;
      default: ;
    endcase
  end

  a_one_unit: assert property (@(posedge clk) disable iff (rst)
    $onehot0({dot_start, div_start, upd_start}));

  a_stage_max: assert property (@(posedge clk) disable iff (rst)
    busy |-> stage <= ORDER);

endmodule

`default_nettype wire

//--- levinson_top.f
+incdir+.
lpc_fmt_pkg.sv
lpc_seq_pkg.sv
sdiv_seq.sv
corr_dot.sv
coef_update.sv
levinson_ctrl.sv
levinson_top.sv
tb_levinson_top.sv

//--- levinson_top.sv
`timescale 1ns/10ps
`default_nettype none

module levinson_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  lpc_fmt_pkg::autocorr_vec_t autocorr,
  output lpc_fmt_pkg::coef_vec_t     coefs,
  output logic                       busy,
  output logic                       done,
  output logic                       unstable
);
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  logic     capture;
  logic     init;
  logic     dot_start;
  logic     dot_valid;
  logic     div_start;
  logic     div_done;
  logic     upd_start;
  logic     upd_done;
  stage_t   stage;
  acc_t     dot_sum;
  div_req_t div_req;
  div_rsp_t div_rsp;
  upd_req_t upd_req;

  levinson_ctrl u_ctrl (
    .clk(clk), .rst(rst), .start(start), .autocorr(autocorr),
    .capture(capture), .init(init), .dot_start(dot_start), .stage(stage),
    .dot_valid(dot_valid), .dot_sum(dot_sum),
    .div_start(div_start), .div_req(div_req), .div_done(div_done), .div_rsp(div_rsp),
    .upd_start(upd_start), .upd_req(upd_req), .upd_done(upd_done),
    .busy(busy), .done(done), .unstable(unstable)
  );

  corr_dot u_dot (
    .clk(clk), .rst(rst), .capture(capture), .autocorr(autocorr), .coefs(coefs),
    .dot_start(dot_start), .stage(stage), .dot_valid(dot_valid), .dot_sum(dot_sum)
  );

  sdiv_seq u_div (
    .clk(clk), .rst(rst), .div_start(div_start), .div_req(div_req),
    .div_done(div_done), .div_rsp(div_rsp)
  );

  coef_update u_upd (
    .clk(clk), .rst(rst), .init(init), .upd_start(upd_start), .upd_req(upd_req),
    .upd_done(upd_done), .coefs(coefs)
  );

endmodule

`default_nettype wire

//--- lpc_fmt_pkg.sv
`default_nettype none

package lpc_fmt_pkg;

  // Predictor order
  localparam int ORDER = 10;

  // Autocorrelation sample width
  localparam int SAMPLE_W = 16;

  // Coefficient format Q2.13
  localparam int COEF_FRAC = 13;
  localparam int COEF_ONE  = 8192;

  // Correlation sums and quotients
  localparam int ACC_W = 40;

  // Autocorrelation value, also the error energy
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Coefficient, Q2.13
  typedef logic signed [15:0] coef_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  // Index 0 is lag 0
  typedef sample_t [ORDER:0] autocorr_vec_t;

  // Index 0 is a0
  typedef coef_t [ORDER:0] coef_vec_t;

endpackage

`default_nettype wire

//--- lpc_seq_pkg.sv
`default_nettype none

package lpc_seq_pkg;

  // One quotient bit per step
  localparam int DIV_STEPS = lpc_fmt_pkg::ACC_W;

  typedef logic [3:0] stage_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_DOT, ST_DIV, ST_KCHK, ST_UPD, ST_EUPD
  } ctrl_state_t;

  typedef struct packed {
    lpc_fmt_pkg::acc_t    dividend;
    lpc_fmt_pkg::sample_t divisor;
  } div_req_t;

  typedef struct packed {
    lpc_fmt_pkg::acc_t quotient;
    logic              div_zero;
  } div_rsp_t;

  typedef struct packed {
    lpc_fmt_pkg::coef_t k;
    stage_t             stage;
  } upd_req_t;

endpackage

`default_nettype wire

//--- sdiv_seq.sv
`timescale 1ns/10ps
`default_nettype none

module sdiv_seq (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  div_start,
  input  lpc_seq_pkg::div_req_t div_req,
  output logic                  div_done,
  output lpc_seq_pkg::div_rsp_t div_rsp
);
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  logic                         run_q;
  logic                         neg_q;
  logic                         zero_q;
  logic [$clog2(DIV_STEPS)-1:0] cnt_q;
  logic [ACC_W-1:0]             dvd_q;      // Dividend shifts out, quotient shifts in
  logic [SAMPLE_W-1:0]          rem_q;
  logic [SAMPLE_W-1:0]          dsr_q;
  logic [ACC_W-1:0]             dvd_abs;
  logic [SAMPLE_W-1:0]          dsr_abs;
  logic [SAMPLE_W:0]            rem_sh;
  logic [SAMPLE_W+1:0]          diff;
  logic                         ge;
  logic [ACC_W-1:0]             quo_nxt;
  logic                         last;

  assign dvd_abs = div_req.dividend[ACC_W-1] ? -div_req.dividend : div_req.dividend;
  assign dsr_abs = div_req.divisor[SAMPLE_W-1] ? -div_req.divisor : div_req.divisor;

  // One restoring step
  assign rem_sh  = {rem_q, dvd_q[ACC_W-1]};
  assign diff    = {1'b0, rem_sh} - {2'b00, dsr_q};
  assign ge      = ~diff[SAMPLE_W+1];
  assign quo_nxt = {dvd_q[ACC_W-2:0], ge};
  assign last    = (cnt_q == DIV_STEPS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q    <= 1'b0;
      cnt_q    <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          run_q    <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      dvd_q  <= dvd_abs;
      dsr_q  <= dsr_abs;
      rem_q  <= '0;
      neg_q  <= div_req.dividend[ACC_W-1] ^ div_req.divisor[SAMPLE_W-1];
      zero_q <= (div_req.divisor == '0);
    end else if (run_q) begin
      dvd_q <= quo_nxt;
      rem_q <= ge ? diff[SAMPLE_W-1:0] : rem_sh[SAMPLE_W-1:0];
      if (last) begin
        // Sign restored on the magnitude, so truncation is toward zero
        if (zero_q)
          div_rsp.quotient <= '0;
        else if (neg_q)
          div_rsp.quotient <= -acc_t'(quo_nxt);
        else
          div_rsp.quotient <= acc_t'(quo_nxt);
        div_rsp.div_zero <= zero_q;
      end
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (rst)
    div_done |=> !div_done);

endmodule

`default_nettype wire

//--- tb_levinson_checks.svh
`ifndef TB_LEVINSON_CHECKS_SVH
`define TB_LEVINSON_CHECKS_SVH

int chk_cnt    = 0;
int val_errs   = 0;
int other_errs = 0;

task automatic check_coef(input string name, input coef_t got, input coef_t exp);
  chk_cnt++;
  if (got !== exp) begin
    val_errs++;
    $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    val_errs++;
    $display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

// Whole coefficient vector, entry by entry
task automatic check_coefs(input coef_vec_t got, input coef_vec_t exp);
  int j;
  for (j = 0; j <= ORDER; j++)
    check_coef($sformatf("coefs[%0d]", j), got[j], exp[j]);
endtask

task automatic report_failure(input string msg);
  other_errs++;
  $display("FAILURE at %0t: %s", $time, msg);
endtask

function automatic int total_errors();
  return val_errs + other_errs;
endfunction

task automatic print_summary();
  $display("Summary: %0d checks, %0d value errors, %0d other failures",
           chk_cnt, val_errs, other_errs);
endtask

`endif

//--- tb_levinson_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_levinson_top;
  import lpc_fmt_pkg::*;
  import lpc_seq_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_RUNS   = 12;   // Runs launched over all tests

  logic          clk;
  logic          rst;
  logic          start;
  autocorr_vec_t autocorr;
  coef_vec_t     coefs;
  logic          busy;
  logic          done;
  logic          unstable;
  integer        seed = 10467;

  `include "tb_levinson_checks.svh"

  levinson_top u_dut (
    .clk(clk), .rst(rst), .start(start), .autocorr(autocorr),
    .coefs(coefs), .busy(busy), .done(done), .unstable(unstable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Worst case cycles of one full run
  function automatic int run_bound_cycles();
    int i;
    int sum;
    sum = 0;
    for (i = 1; i <= ORDER; i++)
      sum += (i + 1) + (DIV_STEPS + 1) + (i / 2 + 1) + 8;
    return sum;
  endfunction

  function automatic longint sat_coef(longint v);
    if (v > 32767)
      return 32767;
    else if (v < -32768)
      return -32768;
    return v;
  endfunction

  function automatic coef_vec_t init_coefs();
    coef_vec_t a;
    a    = '0;
    a[0] = coef_t'(COEF_ONE);
    return a;
  endfunction

  // Levinson-Durbin in integer arithmetic
  task automatic ref_model(input autocorr_vec_t r, output coef_vec_t a_out,
                           output logic unst);
    longint a [ORDER+1];
    longint a_old [ORDER+1];
    longint e;
    longint dot;
    longint q;
    int     i;
    int     j;
    logic   stop;
    for (j = 0; j <= ORDER; j++)
      a[j] = 0;
    a[0] = COEF_ONE;
    e    = longint'($signed(r[0]));
    unst = 1'b0;
    stop = 1'b0;
    for (i = 1; i <= ORDER && !stop; i++) begin
      if (e <= 0) begin
        unst = 1'b1;
        stop = 1'b1;
      end else begin
        dot = 0;
        for (j = 0; j < i; j++)
          dot += a[j] * longint'($signed(r[i - j]));
        q = (-dot) / e;   // Truncates toward zero
        if (q >= COEF_ONE || q <= -COEF_ONE) begin
          unst = 1'b1;
          stop = 1'b1;
        end else begin
          for (j = 0; j <= ORDER; j++)
            a_old[j] = a[j];
          for (j = 1; j < i; j++)
            a[j] = sat_coef(a_old[j] + ((q * a_old[i - j]) >>> COEF_FRAC));
          a[i] = q;
          e = e - ((((q * q) >>> COEF_FRAC) * e) >>> COEF_FRAC);
        end
      end
    end
    for (j = 0; j <= ORDER; j++)
      a_out[j] = coef_t'(a[j]);
  endtask

  // Autocorrelation of 16 random samples, lag 0 scaled to 30000
  task automatic make_random_vec(output autocorr_vec_t r);
    int     x [16];
    longint acc;
    longint r0;
    int     m;
    int     n;
    for (n = 0; n < 16; n++)
      x[n] = $random(seed) % 200;
    r0 = 1;
    for (m = 0; m <= ORDER; m++) begin
      acc = 0;
      for (n = m; n < 16; n++)
        acc += x[n] * x[n - m];
      if (m == 0 && acc > 0)
        r0 = acc;
      r[m] = sample_t'((acc * 30000) / r0);
    end
  endtask

  task automatic pick_stable_vec(output autocorr_vec_t v, output coef_vec_t exp_a,
                                 output logic ok);
    logic exp_u;
    int   tries;
    tries = 0;
    do begin
      make_random_vec(v);
      ref_model(v, exp_a, exp_u);
      tries++;
    end while (exp_u && tries < 50);
    ok = !exp_u;
    if (!ok)
      report_failure("no stable random autocorrelation vector was found");
  endtask

  task automatic launch(input autocorr_vec_t v);
    @(posedge clk);
    autocorr <= v;
    start    <= 1'b1;
    @(posedge clk);
    start    <= 1'b0;
  endtask

  task automatic wait_done(output logic seen);
    int cyc;
    int limit;
    limit = run_bound_cycles();
    seen  = 1'b0;
    cyc   = 0;
    while (!seen && cyc < limit) begin
      @(negedge clk);
      seen = done;
      cyc++;
    end
    if (!seen)
      report_failure("done did not arrive within the run bound");
  endtask

  task automatic run_expect(input autocorr_vec_t v, input coef_vec_t exp_a,
                            input logic exp_u);
    logic seen;
    launch(v);
    wait_done(seen);
    if (seen) begin
      check_coefs(coefs, exp_a);
      check_flag("unstable", unstable, exp_u);
      check_flag("busy", busy, 1'b1);   // Still high in the done cycle
    end
  endtask

  task automatic run_model(input autocorr_vec_t v);
    coef_vec_t exp_a;
    logic      exp_u;
    ref_model(v, exp_a, exp_u);
    run_expect(v, exp_a, exp_u);
  endtask

  task automatic reset_values();
    coef_vec_t zero_vec;
    zero_vec = '0;
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("unstable", unstable, 1'b0);
    check_coefs(coefs, zero_vec);
  endtask

  task automatic white_input();
    autocorr_vec_t v;
    v    = '0;
    v[0] = 12000;
    run_expect(v, init_coefs(), 1'b0);
  endtask

  task automatic decaying_input();
    autocorr_vec_t v;
    real           lag_val;
    int            m;
    lag_val = 16000.0;
    for (m = 0; m <= ORDER; m++) begin
      v[m]    = $rtoi(lag_val + 0.5);
      lag_val = lag_val * 0.8;
    end
    run_model(v);
  endtask

  task automatic random_stable_inputs(input int count);
    autocorr_vec_t v;
    coef_vec_t     exp_a;
    logic          ok;
    int            n;
    for (n = 0; n < count; n++) begin
      pick_stable_vec(v, exp_a, ok);
      if (ok)
        run_expect(v, exp_a, 1'b0);
    end
  endtask

  task automatic unstable_inputs();
    autocorr_vec_t v;
    v    = '0;
    v[0] = 10000;
    v[1] = 10000;   // |k| reaches 1 in stage 1
    run_expect(v, init_coefs(), 1'b1);
    @(negedge clk);
    check_flag("unstable", unstable, 1'b1);   // Held after done
    v = '0;
    run_expect(v, init_coefs(), 1'b1);
  endtask

  task automatic start_while_busy();
    autocorr_vec_t va;
    autocorr_vec_t vb;
    coef_vec_t     exp_a;
    logic          ok_a;
    logic          seen;
    pick_stable_vec(va, exp_a, ok_a);
    vb    = '0;
    vb[0] = 10000;
    vb[1] = 10000;   // Would end unstable if taken
    launch(va);
    repeat (3) @(negedge clk);
    check_flag("busy", busy, 1'b1);
    launch(vb);   // Must be ignored
    wait_done(seen);
    if (seen && ok_a) begin
      check_coefs(coefs, exp_a);
      check_flag("unstable", unstable, 1'b0);
    end
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
  endtask

  task automatic back_to_back_runs();
    autocorr_vec_t va;
    autocorr_vec_t vb;
    coef_vec_t     exp_a;
    coef_vec_t     exp_b;
    logic          ok_a;
    logic          ok_b;
    pick_stable_vec(va, exp_a, ok_a);
    pick_stable_vec(vb, exp_b, ok_b);
    if (ok_a)
      run_expect(va, exp_a, 1'b0);
    if (ok_b)
      run_expect(vb, exp_b, 1'b0);
  endtask

  initial begin
    longint wd_ns;
    wd_ns = 2 * NUM_RUNS * run_bound_cycles() * CLK_PERIOD;
    #(wd_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", wd_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    autocorr = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    reset_values();
    white_input();
    decaying_input();
    random_stable_inputs(5);
    unstable_inputs();
    start_while_busy();
    back_to_back_runs();
    print_summary();
    if (total_errors() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
